// File: source/tok_pkg.sv
// FIFO_DEPTH must equal BLOCK_CREDITS times BLOCK_LEN and stay a power of two
package tok_pkg;

    // Stream byte and write block
    localparam int DATA_W     = 8;
    localparam int BLOCK_LEN  = 8;

    // Peek window seen by the scanners
    localparam int PEEK_W     = 8;

    // Storage and pointers, one extra pointer bit tells full from empty
    localparam int FIFO_DEPTH = 32;
    localparam int PTR_W      = 6;
    localparam int ADDR_W     = PTR_W - 1;

    // Blocks the producer may have in flight after reset
    localparam int BLOCK_CREDITS = 4;

    // Offset bits inside one block
    localparam int OFS_W      = $clog2(BLOCK_LEN);

    // Window position and pop count widths
    localparam int POS_W      = $clog2(PEEK_W);
    localparam int POP_W      = $clog2(PEEK_W + 1);

    // Token terminator
    localparam logic [DATA_W-1:0] DELIM = 8'h0A;

    // Token record fields
    localparam int LEN_W      = 8;
    localparam int SUM_W      = 16;

endpackage

// File: source/peek_window_if.sv
// Window is a thermometer from position 0 and pop_count is only meaningful while pop_en is high
`timescale 1ns/1ps

interface peek_window_if;
    import tok_pkg::*;

    // Bytes at the read pointer, position 0 is the oldest
    logic [PEEK_W-1:0][DATA_W-1:0] window_data;
    logic [PEEK_W-1:0]             window_valid;

    // Entries to drop this cycle, 1 to PEEK_W
    logic                          pop_en;
    logic [POP_W-1:0]              pop_count;

    modport fifo_side (
        output window_data,
        output window_valid,
        input  pop_en,
        input  pop_count
    );

    modport emitter_side (
        input  window_data,
        input  window_valid,
        output pop_en,
        output pop_count
    );

endinterface

// File: source/peek_fifo.sv
// Takes whole blocks only and relies on the producer holding one credit per block written
`timescale 1ns/1ps

module peek_fifo (
    input  logic                                           i_clk,
    input  logic                                           i_nrst,
    input  logic                                           i_wr_en,
    input  logic [tok_pkg::BLOCK_LEN-1:0][tok_pkg::DATA_W-1:0] i_wr_data,
    output logic                                           o_credit,
    peek_window_if.fifo_side                               win
);
    import tok_pkg::*;

    logic [DATA_W-1:0] mem [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  rd_ptr_nxt;
    logic [PTR_W-1:0]  occupancy;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic              full;
    logic              crosses;

    assign wr_addr   = wr_ptr[ADDR_W-1:0];
    assign rd_addr   = rd_ptr[ADDR_W-1:0];
    assign occupancy = wr_ptr - rd_ptr;

    // No room left for another whole block
    assign full = occupancy > PTR_W'((BLOCK_CREDITS - 1) * BLOCK_LEN);

    // One byte per entry in the block store
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            for (int i = 0; i < BLOCK_LEN; i++) begin
                mem[wr_addr + ADDR_W'(i)] <= i_wr_data[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
        end else if (i_wr_en) begin
            wr_ptr <= wr_ptr + PTR_W'(BLOCK_LEN);
        end
    end

    // Peek window from the read pointer
    always_comb begin
        for (int i = 0; i < PEEK_W; i++) begin
            win.window_data[i]  = mem[rd_addr + ADDR_W'(i)];
            win.window_valid[i] = PTR_W'(i) < occupancy;
        end
    end

    // Variable pop
    always_comb begin
        if (win.pop_en) begin
            rd_ptr_nxt = rd_ptr + PTR_W'(win.pop_count);
        end else begin
            rd_ptr_nxt = rd_ptr;
        end
    end

    // A pop never exceeds one block, so at most one boundary per cycle
    assign crosses = rd_ptr_nxt[PTR_W-1:OFS_W] != rd_ptr[PTR_W-1:OFS_W];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_ptr   <= '0;
            o_credit <= 1'b0;
        end else begin
            rd_ptr   <= rd_ptr_nxt;
            o_credit <= crosses;
        end
    end

    // Credit flow from the producer must keep writes away from a full FIFO
    a_no_write_when_full: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_wr_en |-> !full
    ) else $error("peek_fifo: block written while full");

    // The emitter may only drop entries it was shown
    a_pop_within_occupancy: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        win.pop_en |-> (win.pop_count != '0) && (PTR_W'(win.pop_count) <= occupancy)
    ) else $error("peek_fifo: pop of %0d with occupancy %0d", win.pop_count, occupancy);

endmodule

// File: source/delim_finder.sv
// Matches a single fixed delimiter value and ignores bytes outside the valid window
`timescale 1ns/1ps

module delim_finder (
    input  logic [tok_pkg::PEEK_W-1:0][tok_pkg::DATA_W-1:0] i_data,
    input  logic [tok_pkg::PEEK_W-1:0]                      i_valid,
    output logic [tok_pkg::PEEK_W-1:0]                      o_hit
);
    import tok_pkg::*;

    // One comparator per window position
    always_comb begin
        for (int i = 0; i < PEEK_W; i++) begin
            o_hit[i] = i_valid[i] && (i_data[i] == DELIM);
        end
    end

endmodule

// File: source/window_summer.sv
// Sums wrap at SUM_W bits and invalid positions add nothing
`timescale 1ns/1ps

module window_summer (
    input  logic [tok_pkg::PEEK_W-1:0][tok_pkg::DATA_W-1:0] i_data,
    input  logic [tok_pkg::PEEK_W-1:0]                      i_valid,
    output logic [tok_pkg::PEEK_W-1:0][tok_pkg::SUM_W-1:0]  o_prefix_sum
);
    import tok_pkg::*;

    logic [SUM_W-1:0] acc;

    // Inclusive running sum, entry k covers positions 0 to k
    always_comb begin
        acc = '0;
        for (int k = 0; k < PEEK_W; k++) begin
            if (i_valid[k]) begin
                acc = acc + SUM_W'(i_data[k]);
            end
            o_prefix_sum[k] = acc;
        end
    end

endmodule

// File: source/token_emitter.sv
// Token lengths above 255 wrap and an unterminated tail stays in the carry forever
`timescale 1ns/1ps

module token_emitter (
    input  logic                                           i_clk,
    input  logic                                           i_nrst,
    input  logic [tok_pkg::PEEK_W-1:0]                     i_hit,
    input  logic [tok_pkg::PEEK_W-1:0][tok_pkg::SUM_W-1:0] i_prefix_sum,
    input  logic                                           i_tok_ready,
    peek_window_if.emitter_side                            win,
    output logic                                           o_tok_valid,
    output logic [tok_pkg::LEN_W-1:0]                      o_tok_len,
    output logic [tok_pkg::SUM_W-1:0]                      o_tok_sum
);
    import tok_pkg::*;

    logic             hit_found;
    logic [POS_W-1:0] hit_pos;
    logic             can_issue;
    logic [LEN_W-1:0] carry_len;
    logic [SUM_W-1:0] carry_sum;
    logic [LEN_W:0]   len_wide;
    logic [SUM_W-1:0] head_sum;

    // Lowest hit wins
    always_comb begin
        hit_found = 1'b0;
        hit_pos   = '0;
        for (int i = PEEK_W - 1; i >= 0; i--) begin
            if (i_hit[i]) begin
                hit_found = 1'b1;
                hit_pos   = POS_W'(i);
            end
        end
    end

    // Bytes ahead of the delimiter, or the whole window when there is none
    always_comb begin
        if (!hit_found) begin
            head_sum = i_prefix_sum[PEEK_W-1];
        end else if (hit_pos == '0) begin
            head_sum = '0;
        end else begin
            head_sum = i_prefix_sum[hit_pos - POS_W'(1)];
        end
    end

    // Extra top bit only feeds the wrap check
    assign len_wide = {1'b0, carry_len}
                    + (hit_found ? (LEN_W + 1)'(hit_pos) : (LEN_W + 1)'(PEEK_W));

    // Hold the FIFO while a record waits for the sink
    assign can_issue = !o_tok_valid || i_tok_ready;

    assign win.pop_en    = can_issue && (hit_found || (&win.window_valid));
    assign win.pop_count = hit_found ? POP_W'(hit_pos) + POP_W'(1) : POP_W'(PEEK_W);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_tok_valid <= 1'b0;
            carry_len   <= '0;
            carry_sum   <= '0;
        end else begin
            if (win.pop_en && hit_found) begin
                o_tok_valid <= 1'b1;
            end else if (i_tok_ready) begin
                o_tok_valid <= 1'b0;
            end

            if (win.pop_en) begin
                if (hit_found) begin
                    carry_len <= '0;
                    carry_sum <= '0;
                end else begin
                    // Long token continues in the next window
                    carry_len <= len_wide[LEN_W-1:0];
                    carry_sum <= carry_sum + head_sum;
                end
            end
        end
    end

    // Record payload
    always_ff @(posedge i_clk) begin
        if (win.pop_en && hit_found) begin
            o_tok_len <= len_wide[LEN_W-1:0];
            o_tok_sum <= carry_sum + head_sum;
        end
    end

    a_len_no_wrap: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        win.pop_en |-> !len_wide[LEN_W]
    ) else $error("token_emitter: token length exceeds %0d", (1 << LEN_W) - 1);

endmodule

// File: source/token_splitter_top.sv
// Byte 0 of a block sits in i_blk_data bits 7:0 and i_blk_valid is only legal with a credit in hand
`timescale 1ns/1ps

module token_splitter_top (
    input  logic                                               i_clk,
    input  logic                                               i_nrst,
    input  logic                                               i_blk_valid,
    input  logic [tok_pkg::BLOCK_LEN-1:0][tok_pkg::DATA_W-1:0] i_blk_data,
    output logic                                               o_credit,
    input  logic                                               i_tok_ready,
    output logic                                               o_tok_valid,
    output logic [tok_pkg::LEN_W-1:0]                          o_tok_len,
    output logic [tok_pkg::SUM_W-1:0]                          o_tok_sum
);
    import tok_pkg::*;

    logic [PEEK_W-1:0]            hit;
    logic [PEEK_W-1:0][SUM_W-1:0] prefix_sum;

    peek_window_if win_if ();

    peek_fifo u_peek_fifo (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_wr_en   (i_blk_valid),
        .i_wr_data (i_blk_data),
        .o_credit  (o_credit),
        .win       (win_if.fifo_side)
    );

    // Both scanners look at the same window
    delim_finder u_delim_finder (
        .i_data  (win_if.window_data),
        .i_valid (win_if.window_valid),
        .o_hit   (hit)
    );

    window_summer u_window_summer (
        .i_data       (win_if.window_data),
        .i_valid      (win_if.window_valid),
        .o_prefix_sum (prefix_sum)
    );

    token_emitter u_token_emitter (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_hit        (hit),
        .i_prefix_sum (prefix_sum),
        .i_tok_ready  (i_tok_ready),
        .win          (win_if.emitter_side),
        .o_tok_valid  (o_tok_valid),
        .o_tok_len    (o_tok_len),
        .o_tok_sum    (o_tok_sum)
    );

endmodule

// File: verif/tb_token_splitter.sv
// Reads verif/token_cases.hex from the run directory and assumes a delimiter in block 0 and at the end
`timescale 1ns/1ps

module tb_token_splitter;
    import tok_pkg::*;

    localparam int MAX_RECS    = 64;
    localparam int STALL_LIMIT = 400;

    logic                             i_clk;
    logic                             i_nrst;
    logic                             i_blk_valid;
    logic [BLOCK_LEN-1:0][DATA_W-1:0] i_blk_data;
    logic                             o_credit;
    logic                             i_tok_ready;
    logic                             o_tok_valid;
    logic [LEN_W-1:0]                 o_tok_len;
    logic [SUM_W-1:0]                 o_tok_sum;

    logic [79:0]      recs [MAX_RECS];
    logic [63:0]      blocks [$];
    logic [LEN_W-1:0] exp_len [$];
    logic [SUM_W-1:0] exp_sum [$];

    integer seed;
    int     tests_run;
    int     tests_failed;

    token_splitter_top u_token_splitter_top (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_blk_valid (i_blk_valid),
        .i_blk_data  (i_blk_data),
        .o_credit    (o_credit),
        .i_tok_ready (i_tok_ready),
        .o_tok_valid (o_tok_valid),
        .o_tok_len   (o_tok_len),
        .o_tok_sum   (o_tok_sum)
    );

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    task automatic finish_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d error(s)", name, errs);
        end
    endtask

    task automatic load_cases();
        int errs;
        errs = 0;
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = '0;
        end
        $readmemh("verif/token_cases.hex", recs);
        for (int i = 0; i < MAX_RECS; i++) begin
            if (recs[i][79:72] == 8'h01) begin
                blocks.push_back(recs[i][63:0]);
            end else if (recs[i][79:72] == 8'h02) begin
                exp_len.push_back(recs[i][23:16]);
                exp_sum.push_back(recs[i][15:0]);
            end else if (recs[i][79:72] !== 8'h00) begin
                $display("case record %0d has an unknown kind", i);
                errs++;
            end
        end
        if (blocks.size() == 0 || exp_len.size() == 0) begin
            $display("case file holds no blocks or no expected tokens");
            errs++;
        end
        finish_test("load_cases", errs);
    endtask

    task automatic apply_reset(input string name);
        int errs;
        errs = 0;
        i_nrst      = 1'b0;
        i_blk_valid = 1'b0;
        i_tok_ready = 1'b0;
        repeat (4) @(negedge i_clk);
        i_nrst = 1'b1;
        @(negedge i_clk);
        if (o_tok_valid !== 1'b0) begin
            $display("[FAIL] %s o_tok_valid: expected 0, actual %b", name, o_tok_valid);
            errs++;
        end
        if (o_credit !== 1'b0) begin
            $display("[FAIL] %s o_credit: expected 0, actual %b", name, o_credit);
            errs++;
        end
        finish_test(name, errs);
    endtask

    task automatic run_stream(input string name);
        int               credits;
        int               sent;
        int               got;
        int               returned;
        int               stall;
        int               errs;
        int               ready_left;
        logic             progress;
        logic             held_valid;
        logic [LEN_W-1:0] held_len;
        logic [SUM_W-1:0] held_sum;
        credits    = BLOCK_CREDITS;
        sent       = 0;
        got        = 0;
        returned   = 0;
        stall      = 0;
        errs       = 0;
        ready_left = 0;
        held_valid = 1'b0;
        held_len   = '0;
        held_sum   = '0;
        i_tok_ready = 1'b1;
        while ((got < exp_len.size() || returned < blocks.size()) && stall < STALL_LIMIT) begin
            @(negedge i_clk);
            progress = 1'b0;
            // One pulse per freed block
            if (o_credit) begin
                credits++;
                returned++;
                progress = 1'b1;
                if (credits > BLOCK_CREDITS) begin
                    $display("%s: producer holds %0d credits, limit is %0d",
                             name, credits, BLOCK_CREDITS);
                    errs++;
                end
            end
            if (held_valid) begin
                if (!o_tok_valid || o_tok_len !== held_len || o_tok_sum !== held_sum) begin
                    $display("%s: token record changed before it was accepted", name);
                    errs++;
                end
            end
            // Ready runs in random stretches
            if (ready_left == 0) begin
                i_tok_ready = !i_tok_ready;
                ready_left  = $random(seed) & 7;
            end else begin
                ready_left--;
            end
            if (o_tok_valid && i_tok_ready) begin
                if (got >= exp_len.size()) begin
                    $display("%s: extra token with length %0d", name, o_tok_len);
                    errs++;
                end else begin
                    if (o_tok_len !== exp_len[got]) begin
                        $display("[FAIL] %s token %0d len: expected %0d, actual %0d",
                                 name, got, exp_len[got], o_tok_len);
                        errs++;
                    end
                    if (o_tok_sum !== exp_sum[got]) begin
                        $display("[FAIL] %s token %0d sum: expected %h, actual %h",
                                 name, got, exp_sum[got], o_tok_sum);
                        errs++;
                    end
                end
                got++;
                progress = 1'b1;
            end
            held_valid = o_tok_valid && !i_tok_ready;
            held_len   = o_tok_len;
            held_sum   = o_tok_sum;
            // Producer spends one credit per block and idles at random
            if (sent < blocks.size() && credits > 0 && ($random(seed) & 3) != 0) begin
                i_blk_valid = 1'b1;
                i_blk_data  = blocks[sent];
                sent++;
                credits--;
                progress = 1'b1;
            end else begin
                i_blk_valid = 1'b0;
            end
            stall = progress ? 0 : stall + 1;
        end
        i_blk_valid = 1'b0;
        i_tok_ready = 1'b1;
        if (stall >= STALL_LIMIT) begin
            $display("%s: stream stalled with %0d of %0d tokens and %0d of %0d credits",
                     name, got, exp_len.size(), returned, blocks.size());
            errs++;
        end
        // Nothing more may come out in the quiet window
        repeat (16) begin
            @(negedge i_clk);
            if (o_tok_valid) begin
                $display("%s: unexpected token after the stream ended", name);
                errs++;
            end
            if (o_credit) begin
                returned++;
            end
        end
        if (returned != blocks.size()) begin
            $display("[FAIL] %s credits returned: expected %0d, actual %0d",
                     name, blocks.size(), returned);
            errs++;
        end
        finish_test(name, errs);
    endtask

    initial begin
        seed         = 32'h2a66_815c;
        tests_run    = 0;
        tests_failed = 0;
        i_nrst       = 1'b0;
        i_blk_valid  = 1'b0;
        i_blk_data   = '0;
        i_tok_ready  = 1'b0;
        load_cases();
        apply_reset("reset_1");
        run_stream("stream_1");
        // Second reset lands on a pending record and stored bytes
        i_blk_valid = 1'b1;
        i_blk_data  = blocks[0];
        @(negedge i_clk);
        i_blk_valid = 1'b0;
        @(negedge i_clk);
        apply_reset("reset_2");
        run_stream("stream_2");
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/token_cases.hex
// kind 01: block record, 00 pad byte, then 64 data bits with stream byte 0 in the low byte
// kind 02: expected token, 12 zero digits, length byte, 16-bit sum of the bytes before the delimiter
// Short tokens and an empty token between adjacent delimiters
010006050A0A030A0201
02000000000000020003
02000000000000010003
02000000000000000000
// Tail of block A closes in block B
01006050403020100A07
02000000000000030012
// Token spanning blocks B, C and D
0100E0D0C0B0A0908070
01000A440A3322110AF0
020000000000000F0780
02000000000000030066
02000000000000010044
// Token spanning two blocks
01000101010101010101
01000AFFFFFFFF0A0202
020000000000000A000C
020000000000000403FC
// Leading empty tokens then one short token ending the stream
01000A35343332310A0A
02000000000000000000
02000000000000000000
020000000000000500FF

// File: sources.f
source/tok_pkg.sv
source/peek_window_if.sv
source/peek_fifo.sv
source/delim_finder.sv
source/window_summer.sv
source/token_emitter.sv
source/token_splitter_top.sv
verif/tb_token_splitter.sv

// File: Makefile
SIM      = verilator
TOP      = tb_token_splitter
FILELIST = sources.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
